//--- list.f
+incdir+.
lp_pkg.sv
loader_cfg_regs.sv
spmd_loader.sv
credit_counter.sv
mem_bank_array.sv
finish_monitor.sv
lp_top.sv
tb_lp.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_lp
FLIST     := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := RESULT: PASS

SOURCES   := $(filter-out +incdir+%,$(shell cat $(FLIST))) lp_defs.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_lp.sv
/*
 * Testbench of the load subsystem: register access, random loads
 * checked against a memory model, timeout and empty loads.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module tb_lp;

  import lp_pkg::*;

  localparam int    MEM_WORDS  = 1 << `LP_ADDR_W;
  localparam int    ST_FINISH  = 0;
  localparam int    ST_TIMEOUT = 1;
  localparam int    ST_IDLE    = 2;
  localparam int    ST_CRED_LO = 3;
  localparam int    BIG_LIMIT  = 10000;
  localparam data_t ADDR_MASK  = data_t'(MEM_WORDS - 1);
  localparam data_t CYC_MASK   = data_t'((1 << `LP_CYC_W) - 1);

  logic     clk;
  logic     rst_n;
  logic     cfg_we;
  cfg_reg_e cfg_sel;
  data_t    cfg_wdata;
  data_t    cfg_rdata;
  logic     start;
  logic     in_v;
  data_t    in_data;
  logic     in_ready;
  addr_t    rd_addr;
  data_t    rd_data;
  logic     finish;
  logic     timeout;
  logic     busy;

  integer seed;
  data_t  model [MEM_WORDS];

  lp_top uut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .cfg_we_i    (cfg_we),
    .cfg_sel_i   (cfg_sel),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata),
    .start_i     (start),
    .in_v_i      (in_v),
    .in_data_i   (in_data),
    .in_ready_o  (in_ready),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data),
    .finish_o    (finish),
    .timeout_o   (timeout),
    .busy_o      (busy)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting and bus helpers

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    stop_run();
  endtask

  task automatic timeout_error(input string what);
    $display("Timed out waiting for %s", what);
    stop_run();
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  function automatic data_t status_word(input logic fin, input logic tmo,
                                        input logic idle, input credit_t outst);
    data_t w;
    w = '0;
    w[ST_FINISH]  = fin;
    w[ST_TIMEOUT] = tmo;
    w[ST_IDLE]    = idle;
    w[ST_CRED_LO +: `LP_CREDIT_W] = outst;
    return w;
  endfunction

  task automatic cfg_write(input cfg_reg_e sel, input data_t data);
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = data;
    tick();
    cfg_we    = 1'b0;
  endtask

  task automatic cfg_read(input cfg_reg_e sel, output data_t data);
    cfg_sel = sel;
    #1;
    data = cfg_rdata;
    tick();
  endtask

  task automatic expect_reg(input cfg_reg_e sel, input data_t exp, input string name);
    data_t rd;
    cfg_read(sel, rd);
    assert (rd === exp) else value_error(name, rd, exp);
  endtask

  // Registered read returns the word one cycle after the address
  task automatic mem_read(input addr_t addr, output data_t data);
    rd_addr = addr;
    tick();
    data = rd_data;
  endtask

  task automatic snapshot_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_read(addr_t'(i), model[i]);
    end
  endtask

  task automatic check_memory();
    data_t word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_read(addr_t'(i), word);
      assert (word === model[i])
        else value_error($sformatf("rd_data_o at %h", i), word, model[i]);
    end
  endtask

  task automatic poll_credits();
    credit_t outst;
    #1;
    outst = cfg_rdata[ST_CRED_LO +: `LP_CREDIT_W];
    assert (outst <= credit_t'(`LP_MAX_CREDITS))
      else value_error("STATUS outstanding", 32'(outst), `LP_MAX_CREDITS);
  endtask

  task automatic pulse_start();
    start = 1'b1;
    tick();
    start = 1'b0;
  endtask

  task automatic wait_finish(input int max_cycles);
    int n;
    n = 0;
    cfg_sel = STATUS;
    while (finish !== 1'b1 && n < max_cycles) begin
      poll_credits();
      tick();
      n++;
    end
    if (finish !== 1'b1) timeout_error("finish_o");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host word stream

  task automatic load_words(input addr_t base, input int count);
    int    gap;
    int    n;
    data_t word;
    cfg_sel = STATUS;
    for (int idx = 0; idx < count; idx++) begin
      gap = int'($unsigned($random(seed)) % 4);
      repeat (gap) begin
        in_v = 1'b0;
        poll_credits();
        tick();
      end
      word    = $random(seed);
      in_v    = 1'b1;
      in_data = word;
      n       = 0;
      while (in_ready !== 1'b1 && n < 50) begin
        assert (finish === 1'b0) else value_error("finish_o", 32'(finish), 0);
        poll_credits();
        tick();
        n++;
      end
      if (in_ready !== 1'b1) timeout_error("in_ready_o during a load");
      assert (finish === 1'b0) else value_error("finish_o", 32'(finish), 0);
      poll_credits();
      // Word taken on this edge goes to base plus its index
      tick();
      model[base + addr_t'(idx)] = word;
    end
    in_v = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios

  task automatic check_reset_state();
    assert (finish === 1'b0) else value_error("finish_o", 32'(finish), 0);
    assert (timeout === 1'b0) else value_error("timeout_o", 32'(timeout), 0);
    assert (busy === 1'b0) else value_error("busy_o", 32'(busy), 0);
    assert (in_ready === 1'b0) else value_error("in_ready_o", 32'(in_ready), 0);
    expect_reg(STATUS, status_word(1'b0, 1'b0, 1'b1, credit_t'(0)), "STATUS");
  endtask

  task automatic check_cfg_regs();
    data_t b;
    data_t c;
    data_t l;
    data_t junk;
    b    = $random(seed);
    c    = $random(seed);
    l    = $random(seed);
    junk = $random(seed);
    cfg_write(BASE, b);
    cfg_write(COUNT, c);
    cfg_write(LIMIT, l);
    expect_reg(BASE, b & ADDR_MASK, "BASE");
    expect_reg(COUNT, c & ADDR_MASK, "COUNT");
    expect_reg(LIMIT, l & CYC_MASK, "LIMIT");
    cfg_write(STATUS, junk);
    expect_reg(BASE, b & ADDR_MASK, "BASE after STATUS write");
    expect_reg(COUNT, c & ADDR_MASK, "COUNT after STATUS write");
    expect_reg(LIMIT, l & CYC_MASK, "LIMIT after STATUS write");
    expect_reg(STATUS, status_word(1'b0, 1'b0, 1'b1, credit_t'(0)), "STATUS");
  endtask

  task automatic run_random_load();
    data_t r;
    addr_t base;
    int    count;
    r     = $random(seed);
    base  = r[`LP_ADDR_W-1:0];
    count = 1 + int'($unsigned($random(seed)) % 40);
    cfg_write(BASE, data_t'(base));
    cfg_write(COUNT, data_t'(count));
    pulse_start();
    load_words(base, count);
    wait_finish(200);
    assert (timeout === 1'b0) else value_error("timeout_o", 32'(timeout), 0);
    expect_reg(STATUS, status_word(1'b1, 1'b0, 1'b1, credit_t'(0)), "STATUS");
    check_memory();
  endtask

  task automatic check_timeout();
    data_t r;
    data_t st;
    addr_t base;
    int    n;
    r    = $random(seed);
    base = r[`LP_ADDR_W-1:0];
    cfg_write(BASE, data_t'(base));
    cfg_write(COUNT, data_t'(3));
    cfg_write(LIMIT, data_t'(8));
    in_v = 1'b0;
    pulse_start();
    n = 0;
    while (timeout !== 1'b1 && n < 50) begin
      assert (finish === 1'b0) else value_error("finish_o", 32'(finish), 0);
      tick();
      n++;
    end
    if (timeout !== 1'b1) timeout_error("timeout_o");
    assert (finish === 1'b0) else value_error("finish_o", 32'(finish), 0);
    // Loader still waits for its words before it goes idle
    load_words(base, 3);
    n = 0;
    cfg_read(STATUS, st);
    while (st[ST_IDLE] !== 1'b1 && n < 20) begin
      cfg_read(STATUS, st);
      n++;
    end
    if (st[ST_IDLE] !== 1'b1) timeout_error("the loader to go idle");
    assert (timeout === 1'b1) else value_error("timeout_o", 32'(timeout), 1);
    assert (finish === 1'b0) else value_error("finish_o", 32'(finish), 0);
  endtask

  task automatic check_empty_load();
    cfg_write(LIMIT, data_t'(BIG_LIMIT));
    cfg_write(COUNT, '0);
    pulse_start();
    assert (timeout === 1'b0) else value_error("timeout_o after start", 32'(timeout), 0);
    wait_finish(20);
    check_memory();
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_sel   = BASE;
    cfg_wdata = '0;
    start     = 1'b0;
    in_v      = 1'b0;
    in_data   = '0;
    rd_addr   = '0;
    seed      = 89;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_reset_state();
    check_cfg_regs();
    snapshot_memory();
    cfg_write(LIMIT, data_t'(BIG_LIMIT));
    repeat (3) run_random_load();
    check_timeout();
    check_empty_load();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- lp_top.sv
/*
 * Top level of the load subsystem: config registers, loader,
 * credit counter, banked node memory and finish monitor.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module lp_top (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             cfg_we_i,
  input  lp_pkg::cfg_reg_e cfg_sel_i,
  input  lp_pkg::data_t    cfg_wdata_i,
  output lp_pkg::data_t    cfg_rdata_o,
  input  logic             start_i,
  input  logic             in_v_i,
  input  lp_pkg::data_t    in_data_i,
  output logic             in_ready_o,
  input  lp_pkg::addr_t    rd_addr_i,
  output lp_pkg::data_t    rd_data_o,
  output logic             finish_o,
  output logic             timeout_o,
  output logic             busy_o
);

  import lp_pkg::*;

  addr_t   cfg_base;
  addr_t   cfg_count;
  cyc_t    cfg_limit;
  logic    start_go;
  logic    loader_idle;
  addr_t   pkt_addr;
  data_t   pkt_data;
  logic    pkt_v;
  logic    pkt_ready;
  logic    pkt_fire;
  logic    fin_pkt;
  logic    credit_ret;
  logic    credits_full;
  credit_t outstanding;

  // A store moves only with a credit in hand
  assign pkt_fire = pkt_v & pkt_ready;

  loader_cfg_regs u_cfg (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_sel_i     (cfg_sel_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .start_i       (start_i),
    .loader_idle_i (loader_idle),
    .outstanding_i (outstanding),
    .finish_i      (finish_o),
    .timeout_i     (timeout_o),
    .cfg_rdata_o   (cfg_rdata_o),
    .base_o        (cfg_base),
    .count_o       (cfg_count),
    .limit_o       (cfg_limit),
    .start_o       (start_go)
  );

  spmd_loader u_loader (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (start_go),
    .base_i      (cfg_base),
    .count_i     (cfg_count),
    .in_v_i      (in_v_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .pkt_v_o     (pkt_v),
    .pkt_addr_o  (pkt_addr),
    .pkt_data_o  (pkt_data),
    .pkt_ready_i (pkt_ready),
    .fin_pkt_o   (fin_pkt),
    .idle_o      (loader_idle)
  );

  credit_counter u_credit (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .take_i        (pkt_fire),
    .return_i      (credit_ret),
    .ready_o       (pkt_ready),
    .full_o        (credits_full),
    .outstanding_o (outstanding)
  );

  mem_bank_array u_mem (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .wr_v_i       (pkt_fire),
    .wr_addr_i    (pkt_addr),
    .wr_data_i    (pkt_data),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .credit_ret_o (credit_ret)
  );

  finish_monitor u_mon (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_i        (start_go),
    .fin_pkt_i      (fin_pkt),
    .credits_full_i (credits_full),
    .limit_i        (cfg_limit),
    .finish_o       (finish_o),
    .timeout_o      (timeout_o),
    .busy_o         (busy_o)
  );

endmodule

`default_nettype wire

//--- finish_monitor.sv
/*
 * Finish monitor: cycle counter from start, finish once the
 * finish packet is seen and all credits are back, timeout at
 * the configured cycle limit.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module finish_monitor (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         start_i,
  input  logic         fin_pkt_i,
  input  logic         credits_full_i,
  input  lp_pkg::cyc_t limit_i,
  output logic         finish_o,
  output logic         timeout_o,
  output logic         busy_o
);

  import lp_pkg::*;

  localparam cyc_t CYC_ONE = cyc_t'(1);

  cyc_t cyc_r;
  logic busy_r;
  logic fin_seen_r;
  logic finish_r;
  logic timeout_r;
  logic done;

  // fin_pkt counts on the cycle it arrives as well
  assign done = (fin_seen_r || fin_pkt_i) && credits_full_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc_r      <= '0;
      busy_r     <= 1'b0;
      fin_seen_r <= 1'b0;
      finish_r   <= 1'b0;
      timeout_r  <= 1'b0;
    end else if (start_i) begin
      cyc_r      <= '0;
      busy_r     <= 1'b1;
      fin_seen_r <= 1'b0;
      finish_r   <= 1'b0;
      timeout_r  <= 1'b0;
    end else if (busy_r) begin
      cyc_r <= cyc_r + CYC_ONE;
      if (fin_pkt_i) begin
        fin_seen_r <= 1'b1;
      end
      // Finish wins over a timeout in the same cycle
      if (done) begin
        finish_r <= 1'b1;
        busy_r   <= 1'b0;
      end else if (cyc_r >= limit_i) begin
        timeout_r <= 1'b1;
        busy_r    <= 1'b0;
      end
    end
  end

  assign finish_o  = finish_r;
  assign timeout_o = timeout_r;
  assign busy_o    = busy_r;

  a_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(finish_o && timeout_o));

endmodule

`default_nettype wire

//--- mem_bank_array.sv
/*
 * Banked node memory: word banks picked by the low address
 * bits, a store latency pipeline that returns one credit per
 * store, and a registered host read port.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module mem_bank_array (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          wr_v_i,
  input  lp_pkg::addr_t wr_addr_i,
  input  lp_pkg::data_t wr_data_i,
  input  lp_pkg::addr_t rd_addr_i,
  output lp_pkg::data_t rd_data_o,
  output logic          credit_ret_o
);

  import lp_pkg::*;

  localparam int BANK_W     = `LP_BANK_W;
  localparam int ROW_W      = `LP_ADDR_W - `LP_BANK_W;
  localparam int BANK_DEPTH = 1 << ROW_W;

  logic [BANK_W-1:0] wr_bank;
  logic [ROW_W-1:0]  wr_row;
  logic [ROW_W-1:0]  rd_row;
  logic [BANK_W-1:0] rd_bank_r;
  data_t             rd_word [`LP_NUM_BANKS];

  logic [`LP_MEM_LAT-1:0] lat_sr;

  assign wr_bank = wr_addr_i[BANK_W-1:0];
  assign wr_row  = wr_addr_i[`LP_ADDR_W-1:BANK_W];
  assign rd_row  = rd_addr_i[`LP_ADDR_W-1:BANK_W];

  ////////////////////////////////////////////////////////////////////////////
  // Banks

  for (genvar b = 0; b < `LP_NUM_BANKS; b++) begin : g_bank
    data_t mem [BANK_DEPTH];

    always_ff @(posedge clk) begin
      if (wr_v_i && wr_bank == BANK_W'(b)) begin
        mem[wr_row] <= wr_data_i;
      end
      rd_word[b] <= mem[rd_row];
    end
  end

  // Every bank reads its row, the bank select picks one a cycle later
  always_ff @(posedge clk) begin
    rd_bank_r <= rd_addr_i[BANK_W-1:0];
  end

  assign rd_data_o = rd_word[rd_bank_r];

  ////////////////////////////////////////////////////////////////////////////
  // Credit return

  // One bit per store in flight, shifted out after the latency
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lat_sr <= '0;
    end else begin
      lat_sr <= (lat_sr << 1) | `LP_MEM_LAT'(wr_v_i);
    end
  end

  assign credit_ret_o = lat_sr[`LP_MEM_LAT-1];

endmodule

`default_nettype wire

//--- credit_counter.sv
/*
 * Store credit counter: takes a credit per store, gets one
 * back per memory return, gates packet issue on zero.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module credit_counter (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            take_i,
  input  logic            return_i,
  output logic            ready_o,
  output logic            full_o,
  output lp_pkg::credit_t outstanding_o
);

  import lp_pkg::*;

  localparam credit_t MAX_CREDITS = credit_t'(`LP_MAX_CREDITS);
  localparam credit_t CREDIT_ONE  = credit_t'(1);

  // Credits still available
  credit_t count_r;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_r <= MAX_CREDITS;
    end else begin
      case ({take_i, return_i})
        2'b10:   count_r <= count_r - CREDIT_ONE;
        2'b01:   count_r <= count_r + CREDIT_ONE;
        default: count_r <= count_r;
      endcase
    end
  end

  assign ready_o       = (count_r != '0);
  assign full_o        = (count_r == MAX_CREDITS);
  assign outstanding_o = MAX_CREDITS - count_r;

  // No store without a credit, no return beyond the limit
  a_credit_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    (count_r <= MAX_CREDITS) && !(take_i && !return_i && count_r == '0) &&
    !(return_i && !take_i && full_o));

endmodule

`default_nettype wire

//--- spmd_loader.sv
/*
 * Loader FSM: takes host words one at a time and turns each
 * into a store packet at a sequential address from the base,
 * then pulses the finish packet after the last store.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module spmd_loader (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  lp_pkg::addr_t base_i,
  input  lp_pkg::addr_t count_i,
  input  logic          in_v_i,
  input  lp_pkg::data_t in_data_i,
  output logic          in_ready_o,
  output logic          pkt_v_o,
  output lp_pkg::addr_t pkt_addr_o,
  output lp_pkg::data_t pkt_data_o,
  input  logic          pkt_ready_i,
  output logic          fin_pkt_o,
  output logic          idle_o
);

  import lp_pkg::*;

  localparam addr_t ADDR_ONE = addr_t'(1);

  loader_state_e state_r;
  addr_t         remain_r;
  addr_t         addr_r;
  data_t         data_r;

  ////////////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r  <= IDLE;
      remain_r <= '0;
    end else begin
      case (state_r)
        IDLE: begin
          if (start_i) begin
            remain_r <= count_i;
            // Nothing to store, go straight to the finish packet
            state_r  <= (count_i == '0) ? FINISH : LOAD;
          end
        end
        LOAD: begin
          if (in_v_i) begin
            state_r <= SEND;
          end
        end
        SEND: begin
          if (pkt_ready_i) begin
            remain_r <= remain_r - ADDR_ONE;
            state_r  <= (remain_r == ADDR_ONE) ? FINISH : LOAD;
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Packet address and data

  always_ff @(posedge clk) begin
    if (state_r == IDLE && start_i) begin
      addr_r <= base_i;
    end else if (state_r == SEND && pkt_ready_i) begin
      addr_r <= addr_r + ADDR_ONE;
    end
    if (in_ready_o && in_v_i) begin
      data_r <= in_data_i;
    end
  end

  assign in_ready_o = (state_r == LOAD);
  assign pkt_v_o    = (state_r == SEND);
  assign pkt_addr_o = addr_r;
  assign pkt_data_o = data_r;
  assign fin_pkt_o  = (state_r == FINISH);
  assign idle_o     = (state_r == IDLE);

  // Held packet must not change while the credit gate stalls it
  a_pkt_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    pkt_v_o && !pkt_ready_i |=> pkt_v_o && $stable(pkt_addr_o) && $stable(pkt_data_o));

endmodule

`default_nettype wire

//--- loader_cfg_regs.sv
/*
 * Configuration and status registers next to the loader:
 * base address, word count, cycle limit, status readback
 * and start forwarding while the loader is idle.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lp_defs.svh"

module loader_cfg_regs (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             cfg_we_i,
  input  lp_pkg::cfg_reg_e cfg_sel_i,
  input  lp_pkg::data_t    cfg_wdata_i,
  input  logic             start_i,
  input  logic             loader_idle_i,
  input  lp_pkg::credit_t  outstanding_i,
  input  logic             finish_i,
  input  logic             timeout_i,
  output lp_pkg::data_t    cfg_rdata_o,
  output lp_pkg::addr_t    base_o,
  output lp_pkg::addr_t    count_o,
  output lp_pkg::cyc_t     limit_o,
  output logic             start_o
);

  import lp_pkg::*;

  addr_t base_r;
  addr_t count_r;
  cyc_t  limit_r;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      base_r  <= '0;
      count_r <= '0;
      limit_r <= '0;
    end else if (cfg_we_i) begin
      case (cfg_sel_i)
        BASE:    base_r  <= cfg_wdata_i[`LP_ADDR_W-1:0];
        COUNT:   count_r <= cfg_wdata_i[`LP_ADDR_W-1:0];
        LIMIT:   limit_r <= cfg_wdata_i[`LP_CYC_W-1:0];
        // STATUS is read only
        default: ;
      endcase
    end
  end

  // Status layout: [0] finish, [1] timeout, [2] idle, above that outstanding credits
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_sel_i)
      BASE:  cfg_rdata_o[`LP_ADDR_W-1:0] = base_r;
      COUNT: cfg_rdata_o[`LP_ADDR_W-1:0] = count_r;
      LIMIT: cfg_rdata_o[`LP_CYC_W-1:0]  = limit_r;
      default: begin
        cfg_rdata_o[2:0]               = {loader_idle_i, timeout_i, finish_i};
        cfg_rdata_o[`LP_CREDIT_W+2:3]  = outstanding_i;
      end
    endcase
  end

  assign base_o  = base_r;
  assign count_o = count_r;
  assign limit_o = limit_r;

  // A start during a load is dropped here
  assign start_o = start_i & loader_idle_i;

endmodule

`default_nettype wire

//--- lp_pkg.sv
/*
 * Shared types: address, data, credit and cycle vectors,
 * loader FSM states and configuration register indices.
 */

`default_nettype none

`include "lp_defs.svh"

package lp_pkg;

  typedef logic [`LP_ADDR_W-1:0]   addr_t;
  typedef logic [`LP_DATA_W-1:0]   data_t;
  typedef logic [`LP_CREDIT_W-1:0] credit_t;
  typedef logic [`LP_CYC_W-1:0]    cyc_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    SEND   = 2'd2,
    FINISH = 2'd3
  } loader_state_e;

  // Register map of the configuration block
  typedef enum logic [1:0] {
    BASE   = 2'd0,
    COUNT  = 2'd1,
    LIMIT  = 2'd2,
    STATUS = 2'd3
  } cfg_reg_e;

endpackage

`default_nettype wire

//--- lp_defs.svh
/*
 * Shared widths and sizes of the program-load subsystem:
 * address, data and cycle counter widths, credit limit,
 * memory bank count and store latency.
 */

`ifndef LP_DEFS_SVH
`define LP_DEFS_SVH

// Node memory word address and data
`define LP_ADDR_W 10
`define LP_DATA_W 32

// Banks are picked by the low address bits
`define LP_NUM_BANKS 4
`define LP_BANK_W 2

// Outstanding store limit and the counter width for 0..limit
`define LP_MAX_CREDITS 4
`define LP_CREDIT_W 3

// Cycles from store acceptance to credit return
`define LP_MEM_LAT 2

// Cycle counter and timeout limit
`define LP_CYC_W 20

`endif
